//--- src/dw_pkg.sv
// Sizes are fixed for an 8-PE array of 4-lane 8-bit weights; widths below must change together
package dw_pkg;

    // ==============================
    // Array sizes
    // ==============================

    // Number of PE weight banks
    localparam int NUM_PEC    = 8;
    // Width of a PE index
    localparam int PEC_ID_W   = 3;
    // Lanes per weight word and lane width
    localparam int WEI_LANES  = 4;
    localparam int LANE_W     = 8;
    // Weight slots per PE bank
    localparam int WEI_DEPTH  = 4;
    localparam int SLOT_W     = 2;
    // Global buffer depth and pointer width
    localparam int GBUF_DEPTH = 16;
    localparam int GBUF_AW    = 4;

    // ==============================
    // Payload types
    // ==============================

    // One raw weight word, lane 0 in the low byte
    typedef struct packed {
        logic [WEI_LANES-1:0][LANE_W-1:0] lane;
    } wei_word_t;

    // Sparsity flags, set bit marks a nonzero lane
    typedef struct packed {
        logic [WEI_LANES-1:0] mask;
    } wei_flag_t;

    // Decoded word as carried through the fetch pipeline
    typedef struct packed {
        logic      vld;
        wei_word_t word;
    } wei_dec_t;

    // Weight controller states
    typedef enum logic [2:0] {
        ST_IDLE   = 3'b000,
        ST_WAIT   = 3'b001,
        ST_PRE1   = 3'b100,
        ST_PRE2   = 3'b101,
        ST_PRE3   = 3'b111,
        ST_GETWEI = 3'b010
    } ctrl_state_e;

endpackage

//--- src/wei_gbuf.sv
// Show-ahead FIFO of GBUF_DEPTH entries; writes while full are dropped, pops while empty ignored
`timescale 1ns/10ps

module wei_gbuf #(
    parameter type payload_t = dw_pkg::wei_word_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     full
);

    // ==============================
    // Storage and pointers
    // ==============================

    payload_t                   mem [dw_pkg::GBUF_DEPTH];
    logic [dw_pkg::GBUF_AW-1:0] wr_ptr;
    logic [dw_pkg::GBUF_AW-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from an empty one
    logic [dw_pkg::GBUF_AW:0]   count;
    logic                       do_push;
    logic                       do_pop;

    // Qualified strobes
    assign do_push = wr_en && !full;
    assign do_pop  = pop && not_empty;

    // Status flags
    assign not_empty = (count != '0);
    assign full      = (count == (dw_pkg::GBUF_AW + 1)'(dw_pkg::GBUF_DEPTH));

    // Head entry visible before the pop
    assign head = mem[rd_ptr];

    // Entry write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, simultaneous push and pop leave it unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/wei_fetch_pipe.sv
// Advances only on pls_fetch; inputs must be valid whenever pls_fetch fires, fnh_frm flushes all
`timescale 1ns/10ps

module wei_fetch_pipe (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pls_fetch,
    input  logic              fnh_frm,
    input  dw_pkg::wei_word_t in_word,
    input  dw_pkg::wei_flag_t in_flag,
    output dw_pkg::wei_word_t dist_word,
    output logic              dist_rdy
);

    // Stage 1 keeps raw word and flags apart
    logic              s1_vld;
    dw_pkg::wei_word_t s1_word;
    dw_pkg::wei_flag_t s1_flag;
    // Stages 2 and 3 hold decoded words
    dw_pkg::wei_dec_t  s2_dec;
    dw_pkg::wei_dec_t  s3_dec;

    // Zero every lane whose flag bit is clear
    function automatic dw_pkg::wei_word_t zero_lanes(
        input dw_pkg::wei_word_t w,
        input dw_pkg::wei_flag_t f
    );
        dw_pkg::wei_word_t r;
        for (int i = 0; i < dw_pkg::WEI_LANES; i++) begin
            r.lane[i] = f.mask[i] ? w.lane[i] : '0;
        end
        return r;
    endfunction

    // ==============================
    // Stage 1, capture buffer heads
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld  <= 1'b0;
            s1_word <= '0;
            s1_flag <= '0;
        end else if (fnh_frm) begin
            s1_vld <= 1'b0;
        end else if (pls_fetch) begin
            // Fetch only fires with both heads present
            s1_vld  <= 1'b1;
            s1_word <= in_word;
            s1_flag <= in_flag;
        end
    end

    // ==============================
    // Stage 2, sparse decode
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_dec <= '0;
        end else if (fnh_frm) begin
            s2_dec.vld <= 1'b0;
        end else if (pls_fetch) begin
            s2_dec.vld  <= s1_vld;
            s2_dec.word <= zero_lanes(s1_word, s1_flag);
        end
    end

    // ==============================
    // Stage 3, output register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s3_dec <= '0;
        end else if (fnh_frm) begin
            s3_dec.vld <= 1'b0;
        end else if (pls_fetch) begin
            s3_dec <= s2_dec;
        end
    end

    // Word offered to the PE banks
    assign dist_word = s3_dec.word;
    assign dist_rdy  = s3_dec.vld;

endmodule

//--- src/wei_ctrl.sv
// Serves PEs from NUM_PEC-1 down to 0 then wraps; no exit to IDLE once a frame has started
`timescale 1ns/10ps

module wei_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sta,
    input  logic                      wei_val,
    input  logic                      dist_rdy,
    input  logic [dw_pkg::NUM_PEC-1:0] get_wei,
    input  logic                      fnh_frm,
    output logic [dw_pkg::NUM_PEC-1:0] rdy_wei,
    output logic                      pls_fetch
);

    dw_pkg::ctrl_state_e         state;
    dw_pkg::ctrl_state_e         next_state;
    // PE currently being served
    logic [dw_pkg::PEC_ID_W-1:0] pe_ptr;
    // Fetch sources
    logic                        pre_fetch;
    logic                        hand_fetch;
    // Raise a ready bit next edge
    logic                        set_rdy;

    // ==============================
    // State machine
    // ==============================
    always_comb begin
        next_state = state;
        case (state)
            dw_pkg::ST_IDLE: begin
                if (sta) begin
                    next_state = dw_pkg::ST_WAIT;
                end
            end
            // Each prefetch step needs both buffer heads
            dw_pkg::ST_WAIT: begin
                if (wei_val) begin
                    next_state = dw_pkg::ST_PRE1;
                end
            end
            dw_pkg::ST_PRE1: begin
                if (wei_val) begin
                    next_state = dw_pkg::ST_PRE2;
                end
            end
            dw_pkg::ST_PRE2: begin
                if (wei_val) begin
                    next_state = dw_pkg::ST_PRE3;
                end
            end
            // Pipeline primed, stage 3 now valid
            dw_pkg::ST_PRE3: begin
                next_state = dw_pkg::ST_GETWEI;
            end
            // New frame restarts the prefetch
            dw_pkg::ST_GETWEI: begin
                if (fnh_frm) begin
                    next_state = dw_pkg::ST_WAIT;
                end
            end
            default: begin
                next_state = dw_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= dw_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ==============================
    // Fetch pulse
    // ==============================

    // One pulse on each of the three prefetch transitions
    assign pre_fetch = wei_val && (state == dw_pkg::ST_WAIT ||
                                   state == dw_pkg::ST_PRE1 ||
                                   state == dw_pkg::ST_PRE2);

    // Bank takes the word in the ready cycle, so fetch follows get directly
    assign hand_fetch = (|rdy_wei) && (|get_wei) && wei_val;

    assign pls_fetch = pre_fetch || hand_fetch;

    // ==============================
    // PE pointer and ready bits
    // ==============================

    // Descending pointer, steps only on a hand-out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pe_ptr <= dw_pkg::PEC_ID_W'(dw_pkg::NUM_PEC - 1);
        end else if (fnh_frm) begin
            pe_ptr <= dw_pkg::PEC_ID_W'(dw_pkg::NUM_PEC - 1);
        end else if (hand_fetch && state == dw_pkg::ST_GETWEI) begin
            if (pe_ptr == '0) begin
                pe_ptr <= dw_pkg::PEC_ID_W'(dw_pkg::NUM_PEC - 1);
            end else begin
                pe_ptr <= pe_ptr - 1'b1;
            end
        end
    end

    // Next word must stay available, hand-out pops it
    assign set_rdy = (state == dw_pkg::ST_GETWEI) && dist_rdy && wei_val && !(|rdy_wei);

    // One-hot ready bits, cleared on get or frame finish
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_wei <= '0;
        end else if ((|get_wei) || fnh_frm) begin
            rdy_wei <= '0;
        end else if (set_rdy) begin
            rdy_wei <= dw_pkg::NUM_PEC'(1) << pe_ptr;
        end
    end

endmodule

//--- src/pe_wei_bank.sv
// Each bank takes at most WEI_DEPTH words per frame; further ready bits stall until fnh_frm
`timescale 1ns/10ps

module pe_wei_bank (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [dw_pkg::NUM_PEC-1:0]  rdy_wei,
    input  logic                        fnh_frm,
    input  dw_pkg::wei_word_t           dist_word,
    output logic [dw_pkg::NUM_PEC-1:0]  get_wei,
    input  logic [dw_pkg::PEC_ID_W-1:0] rd_pe,
    input  logic [dw_pkg::SLOT_W-1:0]   rd_addr,
    output dw_pkg::wei_word_t           rd_data
);

    // Weight register files, one row per PE
    dw_pkg::wei_word_t         mem [dw_pkg::NUM_PEC][dw_pkg::WEI_DEPTH];
    // Write slot counters, extra bit marks a full bank
    logic [dw_pkg::SLOT_W:0]   wr_cnt [dw_pkg::NUM_PEC];
    logic [dw_pkg::NUM_PEC-1:0] slot_free;

    // ==============================
    // Per-PE write side
    // ==============================
    for (genvar p = 0; p < dw_pkg::NUM_PEC; p++) begin : g_pe

        assign slot_free[p] = (wr_cnt[p] < (dw_pkg::SLOT_W + 1)'(dw_pkg::WEI_DEPTH));

        // Get mirrors ready when a slot is left
        assign get_wei[p] = rdy_wei[p] && slot_free[p];

        // Store at the current slot
        always_ff @(posedge clk) begin
            if (get_wei[p]) begin
                mem[p][wr_cnt[p][dw_pkg::SLOT_W-1:0]] <= dist_word;
            end
        end

        // Slot advance, frame finish rewinds
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_cnt[p] <= '0;
            end else if (fnh_frm) begin
                wr_cnt[p] <= '0;
            end else if (get_wei[p]) begin
                wr_cnt[p] <= wr_cnt[p] + 1'b1;
            end
        end

    end

    // ==============================
    // Read port
    // ==============================

    // Combinational readout of any slot
    assign rd_data = mem[rd_pe][rd_addr];

endmodule

//--- src/wei_dist_top.sv
// Both buffers share wr_en and stay in step; buf_full drops writes, trailing 3 words stay unsent
`timescale 1ns/10ps

module wei_dist_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sta,
    input  logic                        fnh_frm,
    input  logic                        wr_en,
    input  dw_pkg::wei_word_t           wr_word,
    input  dw_pkg::wei_flag_t           wr_flag,
    output logic                        buf_full,
    input  logic [dw_pkg::PEC_ID_W-1:0] rd_pe,
    input  logic [dw_pkg::SLOT_W-1:0]   rd_addr,
    output dw_pkg::wei_word_t           rd_data
);

    // Buffer heads and status
    dw_pkg::wei_word_t          word_head;
    dw_pkg::wei_flag_t          flag_head;
    logic                       word_ne;
    logic                       flag_ne;
    logic                       word_full;
    logic                       flag_full;
    logic                       wei_val;
    // Pipeline and controller links
    logic                       pls_fetch;
    logic                       dist_rdy;
    dw_pkg::wei_word_t          dist_word;
    logic [dw_pkg::NUM_PEC-1:0] rdy_wei;
    logic [dw_pkg::NUM_PEC-1:0] get_wei;

    // Next word present in both buffers
    assign wei_val  = word_ne && flag_ne;
    assign buf_full = word_full || flag_full;

    // ==============================
    // Global buffers
    // ==============================
    wei_gbuf #(
        .payload_t (dw_pkg::wei_word_t)
    ) word_gbuf_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_data   (wr_word),
        .pop       (pls_fetch),
        .head      (word_head),
        .not_empty (word_ne),
        .full      (word_full)
    );

    wei_gbuf #(
        .payload_t (dw_pkg::wei_flag_t)
    ) flag_gbuf_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_data   (wr_flag),
        .pop       (pls_fetch),
        .head      (flag_head),
        .not_empty (flag_ne),
        .full      (flag_full)
    );

    // ==============================
    // Fetch, control and banks
    // ==============================
    wei_fetch_pipe wei_fetch_pipe_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pls_fetch (pls_fetch),
        .fnh_frm   (fnh_frm),
        .in_word   (word_head),
        .in_flag   (flag_head),
        .dist_word (dist_word),
        .dist_rdy  (dist_rdy)
    );

    wei_ctrl wei_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sta       (sta),
        .wei_val   (wei_val),
        .dist_rdy  (dist_rdy),
        .get_wei   (get_wei),
        .fnh_frm   (fnh_frm),
        .rdy_wei   (rdy_wei),
        .pls_fetch (pls_fetch)
    );

    pe_wei_bank pe_wei_bank_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rdy_wei   (rdy_wei),
        .fnh_frm   (fnh_frm),
        .dist_word (dist_word),
        .get_wei   (get_wei),
        .rd_pe     (rd_pe),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

endmodule

//--- testbench/tb_clkgen.sv
// Free-running 8 ns clock; rst_n held low for 5 rising edges, released 1 ns after the last
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // Half period of 4 ns
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Release just after a rising edge, in step with the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- testbench/wei_ctrl_assert.sv
// Bound into wei_ctrl; all properties are disabled while rst_n is low
`timescale 1ns/10ps

module wei_ctrl_assert (
    input logic                       clk,
    input logic                       rst_n,
    input dw_pkg::ctrl_state_e        state,
    input logic                       fnh_frm,
    input logic                       pls_fetch,
    input logic [dw_pkg::NUM_PEC-1:0] rdy_wei
);

    // Running count of failed properties
    int fail_cnt;

    // At most one PE offered a word
    rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rdy_wei))
        else begin
            $error("rdy_wei is neither one-hot nor zero");
            fail_cnt++;
        end

    // A fetch outside GETWEI is one prefetch step of the FSM
    prefetch_step: assert property (@(posedge clk) disable iff (!rst_n)
        (pls_fetch && state != dw_pkg::ST_GETWEI) |=> (state != $past(state)))
        else begin
            $error("pls_fetch fired outside GETWEI without a prefetch step");
            fail_cnt++;
        end

    // Ready bits rise only out of GETWEI
    rdy_only_getwei: assert property (@(posedge clk) disable iff (!rst_n)
        (state != dw_pkg::ST_GETWEI && rdy_wei == '0) |=> (rdy_wei == '0))
        else begin
            $error("rdy_wei set outside GETWEI");
            fail_cnt++;
        end

    // Frame finish drops any pending offer
    rdy_clear_fnh: assert property (@(posedge clk) disable iff (!rst_n)
        fnh_frm |=> (rdy_wei == '0))
        else begin
            $error("rdy_wei not cleared after fnh_frm");
            fail_cnt++;
        end

endmodule

bind wei_ctrl wei_ctrl_assert wei_ctrl_assert_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .fnh_frm   (fnh_frm),
    .pls_fetch (pls_fetch),
    .rdy_wei   (rdy_wei)
);

//--- testbench/tb_wei_dist.sv
// Frames never exceed GBUF_DEPTH words, so banks never fill; slots never written are not checked
`timescale 1ns/10ps

module tb_wei_dist;

    typedef enum logic [1:0] {
        FLAG_ONES,
        FLAG_ALT,
        FLAG_RAND
    } flag_mode_e;

    // One frame of stimulus and the expected buf_full after its writes
    typedef struct packed {
        logic [4:0] n_words;
        flag_mode_e flag_mode;
        logic       gaps;
        logic       exp_full;
    } frame_row_t;

    logic                        clk;
    logic                        rst_n;
    logic                        sta;
    logic                        fnh_frm;
    logic                        wr_en;
    dw_pkg::wei_word_t           wr_word;
    dw_pkg::wei_flag_t           wr_flag;
    logic                        buf_full;
    logic [dw_pkg::PEC_ID_W-1:0] rd_pe;
    logic [dw_pkg::SLOT_W-1:0]   rd_addr;
    dw_pkg::wei_word_t           rd_data;

    frame_row_t        frame_rows [6];
    integer            seed = 32'h3d4638f9;
    int                cycle_cnt;
    int                timeout_limit;
    int                get_count;
    // Reference bank contents
    // Known marks slots written at least once
    dw_pkg::wei_word_t exp_mem   [dw_pkg::NUM_PEC][dw_pkg::WEI_DEPTH];
    logic              exp_known [dw_pkg::NUM_PEC][dw_pkg::WEI_DEPTH];
    // Words and flags of the frame in flight
    dw_pkg::wei_word_t frm_word  [dw_pkg::GBUF_DEPTH];
    dw_pkg::wei_flag_t frm_flag  [dw_pkg::GBUF_DEPTH];

    tb_clkgen tb_clkgen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    wei_dist_top wei_dist_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .sta      (sta),
        .fnh_frm  (fnh_frm),
        .wr_en    (wr_en),
        .wr_word  (wr_word),
        .wr_flag  (wr_flag),
        .buf_full (buf_full),
        .rd_pe    (rd_pe),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // ==============================
    // Helpers
    // ==============================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Each flag bit widened to a byte mask of its lane
    function automatic logic [31:0] apply_flags(input logic [31:0] w, input logic [3:0] f);
        logic [31:0] m;
        m = {{8{f[3]}}, {8{f[2]}}, {8{f[1]}}, {8{f[0]}}};
        return w & m;
    endfunction

    // Back-to-back or gapped writes with buf_full checked before each
    // Old frame ends while the first new word already waits in the buffer
    task automatic write_frame(input frame_row_t row, input bit flush_first);
        int gap;
        for (int i = 0; i < row.n_words; i++) begin
            gap = row.gaps ? int'($unsigned($random(seed)) % 3) : 0;
            wr_en = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            check_hex("buf_full", buf_full, 32'h0);
            wr_en   = 1'b1;
            wr_word = frm_word[i];
            wr_flag = frm_flag[i];
            @(posedge clk);
            #1;
            if (i == 0 && flush_first) begin
                wr_en   = 1'b0;
                fnh_frm = 1'b1;
                @(posedge clk);
                #1;
                fnh_frm = 1'b0;
            end
        end
        wr_en = 1'b0;
        check_hex("buf_full", buf_full, 32'(row.exp_full));
    endtask

    // Delivered word k goes to PE NUM_PEC-1-k%NUM_PEC, slot k/NUM_PEC
    task automatic update_model(input int n);
        int pe;
        int slot;
        for (int k = 0; k < n - 3; k++) begin
            pe   = dw_pkg::NUM_PEC - 1 - (k % dw_pkg::NUM_PEC);
            slot = k / dw_pkg::NUM_PEC;
            if (slot < dw_pkg::WEI_DEPTH) begin
                exp_mem[pe][slot]   = apply_flags(frm_word[k], frm_flag[k]);
                exp_known[pe][slot] = 1'b1;
            end
        end
    endtask

    // Hand-outs reach the target and none may follow
    task automatic wait_quiet(input int target);
        while (get_count < target) begin
            @(posedge clk);
            #1;
        end
        repeat (6) @(posedge clk);
        #1;
        assert (get_count == target) else begin
            report_failure("More weight hand-outs happened than the frame allows");
        end
    endtask

    task automatic read_banks();
        for (int p = 0; p < dw_pkg::NUM_PEC; p++) begin
            for (int s = 0; s < dw_pkg::WEI_DEPTH; s++) begin
                rd_pe   = dw_pkg::PEC_ID_W'(p);
                rd_addr = dw_pkg::SLOT_W'(s);
                @(negedge clk);
                if (exp_known[p][s]) begin
                    check_hex($sformatf("rd_data pe %0d slot %0d", p, s), rd_data, exp_mem[p][s]);
                end
                @(posedge clk);
                #1;
            end
        end
    endtask

    // ==============================
    // Monitors
    // ==============================

    // One bank store per cycle with get high
    always @(negedge clk) begin
        if (rst_n && (|wei_dist_top_inst.get_wei)) begin
            get_count <= get_count + 1;
        end
    end

    always @(negedge clk) begin
        assert (wei_dist_top_inst.wei_ctrl_inst.wei_ctrl_assert_inst.fail_cnt == 0) else begin
            report_failure("A concurrent assertion on wei_ctrl failed");
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= timeout_limit) begin
                report_failure("Timeout, the frames did not finish within the cycle limit");
            end
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int target;
        target = 0;
        // Full buffer first before any pop
        // Gapped rows test the empty stall
        frame_rows[0] = '{5'd16, FLAG_ONES, 1'b0, 1'b1};
        frame_rows[1] = '{5'd11, FLAG_ALT,  1'b0, 1'b0};
        frame_rows[2] = '{5'd12, FLAG_RAND, 1'b1, 1'b0};
        frame_rows[3] = '{5'd9,  FLAG_RAND, 1'b0, 1'b0};
        frame_rows[4] = '{5'd14, FLAG_ALT,  1'b1, 1'b0};
        frame_rows[5] = '{5'd7,  FLAG_ONES, 1'b1, 1'b0};
        sta     = 1'b0;
        fnh_frm = 1'b0;
        wr_en   = 1'b0;
        wr_word = '0;
        wr_flag = '0;
        rd_pe   = '0;
        rd_addr = '0;
        timeout_limit = 0;
        foreach (frame_rows[r]) begin
            timeout_limit += 4 * frame_rows[r].n_words + 60;
        end
        foreach (exp_known[p, s]) begin
            exp_known[p][s] = 1'b0;
        end
        @(posedge rst_n);
        @(posedge clk);
        #1;
        foreach (frame_rows[r]) begin
            for (int i = 0; i < frame_rows[r].n_words; i++) begin
                frm_word[i] = $random(seed);
                case (frame_rows[r].flag_mode)
                    FLAG_ONES: frm_flag[i] = 4'hf;
                    FLAG_ALT:  frm_flag[i] = (i % 2) ? 4'ha : 4'h5;
                    default:   frm_flag[i] = 4'($random(seed));
                endcase
            end
            write_frame(frame_rows[r], r != 0);
            // Controller leaves IDLE once and later frames restart from WAIT
            if (r == 0) begin
                sta = 1'b1;
                @(posedge clk);
                #1;
                sta = 1'b0;
            end
            target += frame_rows[r].n_words - 3;
            wait_quiet(target);
            update_model(frame_rows[r].n_words);
            read_banks();
        end
        // Last frame ends with nothing waiting behind it
        fnh_frm = 1'b1;
        @(posedge clk);
        #1;
        fnh_frm = 1'b0;
        repeat (4) @(posedge clk);
        if (wei_dist_top_inst.wei_ctrl_inst.wei_ctrl_assert_inst.fail_cnt == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure("A concurrent assertion on wei_ctrl failed");
        end
    end

endmodule

//--- tb.f
src/dw_pkg.sv
src/wei_gbuf.sv
src/wei_fetch_pipe.sv
src/wei_ctrl.sv
src/pe_wei_bank.sv
src/wei_dist_top.sv
testbench/tb_clkgen.sv
testbench/wei_ctrl_assert.sv
testbench/tb_wei_dist.sv
